// ==== dv/tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
    output logic clk_o
);

    // 8 ns period
    initial begin
        clk_o = 1'b0;
    end

    always #4 clk_o = ~clk_o;

endmodule

// ==== dv/tbMiniBackend.sv ====
`timescale 1ns/1ps

module tbMiniBackend;

    logic          clk;
    logic          rstN_i;
    logic          instValid_i;
    logic [31:0]   instWord_i;
    logic          stall_o;
    logic          wbValid_o;
    logic [4:0]    wbRd_o;
    logic [31:0]   wbData_o;

    // reference state, updated in program order
    logic [31:0]   refRegs [32];
    logic [31:0]   expVal [32];
    bit            outstanding [32];
    string         slotTest [32];

    string         testName;
    int            errors;
    int            accepted;
    int            retired;
    bit            inBurst;
    bit            sawFullStall;

    tbClock i_clk (
        .clk_o (clk)
    );

    miniBackend i_dut (
        .clk         (clk),
        .rstN_i      (rstN_i),
        .instValid_i (instValid_i),
        .instWord_i  (instWord_i),
        .stall_o     (stall_o),
        .wbValid_o   (wbValid_o),
        .wbRd_o      (wbRd_o),
        .wbData_o    (wbData_o)
    );

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] refExec(input logic [3:0] op, input logic [31:0] a,
                                            input logic [31:0] b, input logic [17:0] imm);
        logic [31:0] immExt;
        immExt = {{14{imm[17]}}, imm};
        case (op)
            4'd0:    return a + b;
            4'd1:    return a - b;
            4'd2:    return a & b;
            4'd3:    return a | b;
            4'd4:    return a ^ b;
            4'd5:    return a << b[4:0];
            4'd6:    return a >> b[4:0];
            4'd7:    return a + immExt;
            4'd8:    return a * b;
            default: return 32'h0;
        endcase
    endfunction

    function automatic int pendingCount();
        int n;
        n = 0;
        for (int i = 0; i < 32; i++) begin
            n += outstanding[i];
        end
        return n;
    endfunction

    // sample mid-cycle, where inputs and registered outputs are stable
    always @(negedge clk) begin : monitor
        logic [4:0]  rd;
        logic [31:0] res;
        if (rstN_i) begin
            // retire before accept, a freed rd can be reused in the same cycle
            if (wbValid_o) begin
                retired++;
                assert (outstanding[wbRd_o]) else begin
                    errors++;
                    $display("writeback to x%0d without an outstanding write", wbRd_o);
                end
                if (outstanding[wbRd_o]) begin
                    assert (wbData_o === expVal[wbRd_o]) else begin
                        errors++;
                        $display("[FAIL] %s: x%0d expected %h actual %h",
                                 slotTest[wbRd_o], wbRd_o, expVal[wbRd_o], wbData_o);
                    end
                    outstanding[wbRd_o] = 1'b0;
                end
            end
            if (instValid_i && !stall_o) begin
                rd  = instWord_i[27:23];
                res = refExec(instWord_i[31:28], refRegs[instWord_i[22:18]],
                              refRegs[instWord_i[17:13]], instWord_i[17:0]);
                assert (!outstanding[rd]) else begin
                    errors++;
                    $display("instruction accepted while a write to x%0d was pending", rd);
                end
                refRegs[rd]     = res;
                expVal[rd]      = res;
                outstanding[rd] = 1'b1;
                slotTest[rd]    = testName;
                accepted++;
            end
            if (inBurst && stall_o) begin
                sawFullStall = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] buildWord(input logic [3:0] op, input logic [4:0] rd,
                                              input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] w;
        // low bits stay random: immediate for addi, unused otherwise
        w = $urandom;
        w[31:28] = op;
        w[27:23] = rd;
        w[22:18] = rs1;
        if (op != 4'd7) begin
            w[17:13] = rs2;
        end
        return w;
    endfunction

    task automatic randomPhase(input int cycles, input int regMax);
        logic [3:0] op;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            // code 9 is undefined and must retire as zero
            op = 4'($urandom_range(9, 0));
            instValid_i <= ($urandom_range(99, 0) < 70);
            instWord_i  <= buildWord(op, 5'($urandom_range(regMax, 0)),
                                     5'($urandom_range(regMax, 0)),
                                     5'($urandom_range(regMax, 0)));
        end
        @(posedge clk);
        instValid_i <= 1'b0;
    endtask

    task automatic waitDrain(input int limit);
        int n;
        n = 0;
        while (pendingCount() != 0 && n < limit) begin
            @(posedge clk);
            n++;
        end
        assert (pendingCount() == 0) else begin
            errors++;
            $display("timeout: %0d writes still outstanding after %0d cycles",
                     pendingCount(), limit);
        end
    endtask

    initial begin
        void'($urandom(32'h4069));
        rstN_i       = 1'b0;
        instValid_i  = 1'b0;
        instWord_i   = '0;
        errors       = 0;
        accepted     = 0;
        retired      = 0;
        inBurst      = 1'b0;
        sawFullStall = 1'b0;
        testName     = "reset";
        for (int i = 0; i < 32; i++) begin
            refRegs[i]     = '0;
            expVal[i]      = '0;
            outstanding[i] = 1'b0;
            slotTest[i]    = "none";
        end

        repeat (5) @(posedge clk);
        rstN_i <= 1'b1;

        testName = "idleAfterReset";
        repeat (5) begin
            @(negedge clk);
            assert (!stall_o && !wbValid_o) else begin
                errors++;
                $display("stall_o or wbValid_o high while idle after reset");
            end
        end

        testName = "randomMix";
        randomPhase(400, 31);
        testName = "denseDeps";
        randomPhase(400, 3);
        waitDrain(200);

        // independent multiplies, only a full set of lanes can stall them
        testName = "mulBurst";
        inBurst  = 1'b1;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            instValid_i <= 1'b1;
            instWord_i  <= buildWord(4'd8, 5'(8 + i), 5'(20 + i % 4), 5'(23 - i % 4));
        end
        @(posedge clk);
        instValid_i <= 1'b0;
        inBurst = 1'b0;
        assert (sawFullStall) else begin
            errors++;
            $display("stall_o never rose while the multiply burst filled the lanes");
        end

        waitDrain(200);
        repeat (3) @(posedge clk);
        assert (accepted == retired) else begin
            errors++;
            $display("accepted %0d instructions but saw %0d writebacks", accepted, retired);
        end

        $display("errors: %0d, accepted: %0d, retired: %0d", errors, accepted, retired);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/bePkg.sv
rtl/issueIf.sv
rtl/wbIf.sv
rtl/regFile.sv
rtl/dispatchUnit.sv
rtl/aluLane.sv
rtl/writebackArb.sv
rtl/miniBackend.sv
dv/tbClock.sv
dv/tbMiniBackend.sv

// ==== rtl/aluLane.sv ====
`timescale 1ns/1ps

module aluLane (
    input  logic       clk,
    input  logic       rstN_i,
    issueIf.lane       iss_i,
    wbIf.lane          wb_o
);

    bePkg::opcode_t                  opReg;
    logic [bePkg::RegIdxW-1:0]       rdReg;
    logic [bePkg::DataW-1:0]         aReg;
    logic [bePkg::DataW-1:0]         bReg;

    logic                            busy;
    logic                            resValid;
    logic [bePkg::MulCntW-1:0]       cnt;
    logic [bePkg::DataW-1:0]         result;
    logic [bePkg::DataW-1:0]         resData;

    ////////////////////////////////////////////////////////////
    // execute
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (opReg)
            bePkg::OpAdd,
            bePkg::OpAddi: result = aReg + bReg;
            bePkg::OpSub:  result = aReg - bReg;
            bePkg::OpAnd:  result = aReg & bReg;
            bePkg::OpOr:   result = aReg | bReg;
            bePkg::OpXor:  result = aReg ^ bReg;
            bePkg::OpSll:  result = aReg << bReg[$clog2(bePkg::DataW)-1:0];
            bePkg::OpSrl:  result = aReg >> bReg[$clog2(bePkg::DataW)-1:0];
            // low word of the product
            bePkg::OpMul:  result = aReg * bReg;
            default:       result = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            busy     <= 1'b0;
            resValid <= 1'b0;
            cnt      <= '0;
        end else if (resValid) begin
            if (wb_o.grant) begin
                busy     <= 1'b0;
                resValid <= 1'b0;
            end
        end else if (busy) begin
            // countdown reaches zero one cycle after capture for alu ops
            if (cnt == '0) begin
                resValid <= 1'b1;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end else if (iss_i.valid) begin
            busy <= 1'b1;
            cnt  <= (iss_i.op == bePkg::OpMul) ?
                    bePkg::MulCntW'(bePkg::MulLatency - 1) : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && iss_i.valid) begin
            opReg <= iss_i.op;
            rdReg <= iss_i.rd;
            aReg  <= iss_i.opA;
            bReg  <= iss_i.opB;
        end
        if (busy && !resValid && cnt == '0) begin
            resData <= result;
        end
    end

    assign iss_i.busy    = busy;
    assign wb_o.resValid = resValid;
    assign wb_o.resRd    = rdReg;
    assign wb_o.resData  = resData;

endmodule

// ==== rtl/bePkg.sv ====
package bePkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////

    localparam int NumLanes   = 4;
    localparam int NumRegs    = 32;
    localparam int RegIdxW    = 5;
    localparam int DataW      = 32;

    // cycles a multiply stays in a lane before its result is offered
    localparam int MulLatency = 3;
    localparam int MulCntW    = $clog2(MulLatency);

    ////////////////////////////////////////////////////////////
    // opcodes
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        OpAdd  = 4'd0,
        OpSub  = 4'd1,
        OpAnd  = 4'd2,
        OpOr   = 4'd3,
        OpXor  = 4'd4,
        OpSll  = 4'd5,
        OpSrl  = 4'd6,
        OpAddi = 4'd7,
        OpMul  = 4'd8
    } opcode_t;

    ////////////////////////////////////////////////////////////
    // instruction word
    ////////////////////////////////////////////////////////////

    // opcode, rd and rs1 sit at the same bit positions in both views
    typedef union packed {
        struct packed {
            opcode_t              opcode;
            logic [RegIdxW-1:0]   rd;
            logic [RegIdxW-1:0]   rs1;
            logic [RegIdxW-1:0]   rs2;
            logic [12:0]          unused;
        } rType;
        struct packed {
            opcode_t              opcode;
            logic [RegIdxW-1:0]   rd;
            logic [RegIdxW-1:0]   rs1;
            logic signed [17:0]   imm;
        } iType;
    } instWord_t;

endpackage

// ==== rtl/dispatchUnit.sv ====
`timescale 1ns/1ps

module dispatchUnit (
    input  logic                        clk,
    input  logic                        rstN_i,

    input  logic                        instValid_i,
    input  bePkg::instWord_t            instWord_i,
    output logic                        stall_o,

    // register file side
    output logic [bePkg::RegIdxW-1:0]   rdIdxA_o,
    output logic [bePkg::RegIdxW-1:0]   rdIdxB_o,
    output logic [bePkg::RegIdxW-1:0]   rdIdxD_o,
    input  logic [bePkg::DataW-1:0]     rdDataA_i,
    input  logic [bePkg::DataW-1:0]     rdDataB_i,
    input  logic                        pendA_i,
    input  logic                        pendB_i,
    input  logic                        pendD_i,
    output logic                        setPend_o,
    output logic [bePkg::RegIdxW-1:0]   setIdx_o,

    issueIf.dispatch                    issue_o [bePkg::NumLanes]
);

    bePkg::opcode_t                  op;
    logic                            isImm;
    logic signed [bePkg::DataW-1:0]  immExt;
    logic                            accept;

    logic [bePkg::NumLanes-1:0]      laneFree;
    logic [bePkg::NumLanes-1:0]      selOh;

    // issue registers, payload is shared and only the valid is per lane
    logic [bePkg::NumLanes-1:0]      issValid;
    bePkg::opcode_t                  issOp;
    logic [bePkg::RegIdxW-1:0]       issRd;
    logic [bePkg::DataW-1:0]         issA;
    logic [bePkg::DataW-1:0]         issB;

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    assign op       = instWord_i.rType.opcode;
    assign isImm    = (op == bePkg::OpAddi);
    assign immExt   = instWord_i.iType.imm;

    assign rdIdxA_o = instWord_i.rType.rs1;
    assign rdIdxB_o = instWord_i.rType.rs2;
    assign rdIdxD_o = instWord_i.rType.rd;

    ////////////////////////////////////////////////////////////
    // hazards and lane select
    ////////////////////////////////////////////////////////////

    // a lane with a valid in flight is not busy yet but is taken
    assign stall_o = pendA_i | (pendB_i & ~isImm) | pendD_i | ~|laneFree;
    assign accept  = instValid_i & ~stall_o;

    // lowest set bit of the free mask
    assign selOh   = laneFree & (~laneFree + 1'b1);

    assign setPend_o = accept;
    assign setIdx_o  = instWord_i.rType.rd;

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            issValid <= '0;
        end else begin
            issValid <= accept ? selOh : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            issOp <= op;
            issRd <= instWord_i.rType.rd;
            issA  <= rdDataA_i;
            issB  <= isImm ? immExt : rdDataB_i;
        end
    end

    for (genvar g = 0; g < bePkg::NumLanes; g++) begin : gLane
        assign laneFree[g]     = ~issue_o[g].busy & ~issValid[g];
        assign issue_o[g].valid = issValid[g];
        assign issue_o[g].op    = issOp;
        assign issue_o[g].rd    = issRd;
        assign issue_o[g].opA   = issA;
        assign issue_o[g].opB   = issB;
    end

endmodule

// ==== rtl/issueIf.sv ====
`timescale 1ns/1ps

interface issueIf;

    // payload is only meaningful while valid is high
    logic                        valid;
    bePkg::opcode_t              op;
    logic [bePkg::RegIdxW-1:0]   rd;
    logic [bePkg::DataW-1:0]     opA;
    logic [bePkg::DataW-1:0]     opB;

    // lane holds an instruction until its result is granted
    logic                        busy;

    modport dispatch (
        output valid,
        output op,
        output rd,
        output opA,
        output opB,
        input  busy
    );

    modport lane (
        input  valid,
        input  op,
        input  rd,
        input  opA,
        input  opB,
        output busy
    );

endinterface

// ==== rtl/miniBackend.sv ====
`timescale 1ns/1ps

module miniBackend (
    input  logic                        clk,
    input  logic                        rstN_i,
    input  logic                        instValid_i,
    input  logic [bePkg::DataW-1:0]     instWord_i,
    output logic                        stall_o,
    output logic                        wbValid_o,
    output logic [bePkg::RegIdxW-1:0]   wbRd_o,
    output logic [bePkg::DataW-1:0]     wbData_o
);

    logic [bePkg::RegIdxW-1:0]   rdIdxA;
    logic [bePkg::RegIdxW-1:0]   rdIdxB;
    logic [bePkg::RegIdxW-1:0]   rdIdxD;
    logic [bePkg::DataW-1:0]     rdDataA;
    logic [bePkg::DataW-1:0]     rdDataB;
    logic                        pendA;
    logic                        pendB;
    logic                        pendD;
    logic                        setPend;
    logic [bePkg::RegIdxW-1:0]   setIdx;
    logic                        wrEn;
    logic [bePkg::RegIdxW-1:0]   wrIdx;
    logic [bePkg::DataW-1:0]     wrData;

    issueIf issueBus [bePkg::NumLanes] ();
    wbIf    wbBus    [bePkg::NumLanes] ();

    regFile i_regFile (
        .clk       (clk),
        .rstN_i    (rstN_i),
        .rdIdxA_i  (rdIdxA),
        .rdIdxB_i  (rdIdxB),
        .rdIdxD_i  (rdIdxD),
        .rdDataA_o (rdDataA),
        .rdDataB_o (rdDataB),
        .pendA_o   (pendA),
        .pendB_o   (pendB),
        .pendD_o   (pendD),
        .setPend_i (setPend),
        .setIdx_i  (setIdx),
        .wrEn_i    (wrEn),
        .wrIdx_i   (wrIdx),
        .wrData_i  (wrData)
    );

    dispatchUnit i_dispatch (
        .clk         (clk),
        .rstN_i      (rstN_i),
        .instValid_i (instValid_i),
        .instWord_i  (instWord_i),
        .stall_o     (stall_o),
        .rdIdxA_o    (rdIdxA),
        .rdIdxB_o    (rdIdxB),
        .rdIdxD_o    (rdIdxD),
        .rdDataA_i   (rdDataA),
        .rdDataB_i   (rdDataB),
        .pendA_i     (pendA),
        .pendB_i     (pendB),
        .pendD_i     (pendD),
        .setPend_o   (setPend),
        .setIdx_o    (setIdx),
        .issue_o     (issueBus)
    );

    for (genvar g = 0; g < bePkg::NumLanes; g++) begin : gLane
        aluLane i_lane (
            .clk    (clk),
            .rstN_i (rstN_i),
            .iss_i  (issueBus[g]),
            .wb_o   (wbBus[g])
        );
    end

    writebackArb i_wbArb (
        .clk       (clk),
        .rstN_i    (rstN_i),
        .wb_i      (wbBus),
        .wrEn_o    (wrEn),
        .wrIdx_o   (wrIdx),
        .wrData_o  (wrData),
        .wbValid_o (wbValid_o),
        .wbRd_o    (wbRd_o),
        .wbData_o  (wbData_o)
    );

endmodule

// ==== rtl/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic                        clk,
    input  logic                        rstN_i,

    // operand reads
    input  logic [bePkg::RegIdxW-1:0]   rdIdxA_i,
    input  logic [bePkg::RegIdxW-1:0]   rdIdxB_i,
    input  logic [bePkg::RegIdxW-1:0]   rdIdxD_i,
    output logic [bePkg::DataW-1:0]     rdDataA_o,
    output logic [bePkg::DataW-1:0]     rdDataB_o,
    output logic                        pendA_o,
    output logic                        pendB_o,
    output logic                        pendD_o,

    // scoreboard set from dispatch
    input  logic                        setPend_i,
    input  logic [bePkg::RegIdxW-1:0]   setIdx_i,

    // writeback, also clears the pending bit
    input  logic                        wrEn_i,
    input  logic [bePkg::RegIdxW-1:0]   wrIdx_i,
    input  logic [bePkg::DataW-1:0]     wrData_i
);

    logic [bePkg::DataW-1:0]   regs [bePkg::NumRegs];
    logic [bePkg::NumRegs-1:0] pend;

    // no bypass, a pending source stalls dispatch anyway
    assign rdDataA_o = regs[rdIdxA_i];
    assign rdDataB_o = regs[rdIdxB_i];
    assign pendA_o   = pend[rdIdxA_i];
    assign pendB_o   = pend[rdIdxB_i];
    assign pendD_o   = pend[rdIdxD_i];

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            regs <= '{default: '0};
            pend <= '0;
        end else begin
            if (wrEn_i) begin
                regs[wrIdx_i] <= wrData_i;
                pend[wrIdx_i] <= 1'b0;
            end
            // set comes last so it wins over a clear of the same index
            if (setPend_i) begin
                pend[setIdx_i] <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/wbIf.sv ====
`timescale 1ns/1ps

interface wbIf;

    logic                        resValid;
    logic [bePkg::RegIdxW-1:0]   resRd;
    logic [bePkg::DataW-1:0]     resData;

    // one-cycle pulse, result leaves the lane on this edge
    logic                        grant;

    modport lane (
        output resValid,
        output resRd,
        output resData,
        input  grant
    );

    modport arb (
        input  resValid,
        input  resRd,
        input  resData,
        output grant
    );

endinterface

// ==== rtl/writebackArb.sv ====
`timescale 1ns/1ps

module writebackArb (
    input  logic                        clk,
    input  logic                        rstN_i,
    wbIf.arb                            wb_i [bePkg::NumLanes],

    // register file write
    output logic                        wrEn_o,
    output logic [bePkg::RegIdxW-1:0]   wrIdx_o,
    output logic [bePkg::DataW-1:0]     wrData_o,

    // retired result
    output logic                        wbValid_o,
    output logic [bePkg::RegIdxW-1:0]   wbRd_o,
    output logic [bePkg::DataW-1:0]     wbData_o
);

    logic [bePkg::NumLanes-1:0]   laneValid;
    logic [bePkg::NumLanes-1:0]   grantOh;
    logic [bePkg::RegIdxW-1:0]    laneRd   [bePkg::NumLanes];
    logic [bePkg::DataW-1:0]      laneData [bePkg::NumLanes];

    for (genvar g = 0; g < bePkg::NumLanes; g++) begin : gLane
        assign laneValid[g]  = wb_i[g].resValid;
        assign laneRd[g]     = wb_i[g].resRd;
        assign laneData[g]   = wb_i[g].resData;
        assign wb_i[g].grant = grantOh[g];
    end

    // fixed priority, lane 0 first
    assign grantOh = laneValid & (~laneValid + 1'b1);
    assign wrEn_o  = |laneValid;

    always_comb begin
        wrIdx_o  = '0;
        wrData_o = '0;
        for (int i = 0; i < bePkg::NumLanes; i++) begin
            if (grantOh[i]) begin
                wrIdx_o  = laneRd[i];
                wrData_o = laneData[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            wbValid_o <= 1'b0;
        end else begin
            wbValid_o <= wrEn_o;
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn_o) begin
            wbRd_o   <= wrIdx_o;
            wbData_o <= wrData_o;
        end
    end

endmodule
